// ==== hdl/bf16_settings.svh ====
`ifndef BF16_SETTINGS_SVH
`define BF16_SETTINGS_SVH

// bfloat16 encoding constants

// exponent bias of the encoded exponent field
`define BF16_EXP_BIAS 127

// largest encoded exponent a finite result may carry
`define BF16_MAX_EXP 254

// mantissa written out on saturation
`define BF16_SAT_MANTISSA 7'h7f

// result queue sizing

// default entry count of the output FIFO, any value of 2 or more works
`define BF16_QUEUE_DEPTH 4

`endif

// ==== hdl/bf16_pkg.sv ====
package bf16_pkg;

	// one bfloat16 value as it appears on the ports
	typedef struct packed {
		logic       sign;
		logic [7:0] exp;
		logic [6:0] mantissa;
	} bf16_t;

	// encoded exponent field
	typedef logic [7:0] bf16_exp_t;

	// significand with the hidden one in bit 7
	typedef logic [7:0] bf16_sig_t;

	// full product of two significands
	typedef logic [15:0] bf16_prod_t;

	// unbiased working exponent inside the core
	// 10 bits signed covers -127 up to 384 after the normalize step
	typedef logic signed [9:0] bf16_wide_exp_t;

endpackage

// ==== hdl/bf16_operand_unpack.sv ====
`timescale 1ns/1ps

module bf16_operand_unpack
	import bf16_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	// operand port
	input  logic      in_valid,
	output logic      in_ready,
	input  bf16_t     in_a,
	input  bf16_t     in_b,

	// unpacked stage towards the core
	output logic      up_valid,
	input  logic      up_ready,
	output logic      up_sign,
	output bf16_sig_t up_sig_a,
	output bf16_sig_t up_sig_b,
	output bf16_exp_t up_exp_a,
	output bf16_exp_t up_exp_b,
	output logic      up_zero
);

	logic load;

	// stage takes a new pair when empty or when its pair leaves now
	assign in_ready = !up_valid || up_ready;
	assign load     = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			up_valid <= 1'b0;
		end
		else if (in_ready)
		begin
			up_valid <= in_valid;
		end
	end

	// operand fields, loaded only on an accepted pair
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			// result sign is fixed here already
			up_sign  <= in_a.sign ^ in_b.sign;

			// hidden one in front of the stored bits
			up_sig_a <= {1'b1, in_a.mantissa};
			up_sig_b <= {1'b1, in_b.mantissa};

			up_exp_a <= in_a.exp;
			up_exp_b <= in_b.exp;

			// exponent 0 means zero, denormals flushed
			up_zero  <= (in_a.exp == 8'd0) || (in_b.exp == 8'd0);
		end
	end

endmodule

// ==== hdl/bf16_mul_core.sv ====
`timescale 1ns/1ps
`include "bf16_settings.svh"

module bf16_mul_core
	import bf16_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	// unpacked operands from the input side
	input  logic      up_valid,
	output logic      up_ready,
	input  logic      up_sign,
	input  bf16_sig_t up_sig_a,
	input  bf16_sig_t up_sig_b,
	input  bf16_exp_t up_exp_a,
	input  bf16_exp_t up_exp_b,
	input  logic      up_zero,

	// finished result towards the queue
	output logic      core_valid,
	input  logic      core_ready,
	output bf16_t     core_result
);

	localparam bf16_wide_exp_t EXP_BIAS  = bf16_wide_exp_t'(`BF16_EXP_BIAS);
	localparam bf16_wide_exp_t SAT_LIMIT = bf16_wide_exp_t'(`BF16_MAX_EXP + 1);
	localparam bf16_exp_t      MAX_EXP   = bf16_exp_t'(`BF16_MAX_EXP);

	// stage 1 state
	logic           s1_valid;
	logic           s1_ready;
	logic           s1_sign;
	bf16_prod_t     s1_prod;
	bf16_wide_exp_t s1_exp;
	bf16_wide_exp_t s1_exp_next;

	// stage 2 state and its next value
	logic           s2_valid;
	bf16_prod_t     norm_prod;
	bf16_wide_exp_t norm_exp;
	bf16_t          s2_result_next;

	// a stage moves when empty or when the next one takes its item
	assign s1_ready = !s2_valid || core_ready;
	assign up_ready = !s1_valid || s1_ready;

	// both exponents carry the bias, so one bias is removed
	assign s1_exp_next = bf16_wide_exp_t'({2'b00, up_exp_a})
		+ bf16_wide_exp_t'({2'b00, up_exp_b})
		- EXP_BIAS;

	// stage 1 multiply
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
		end
		else if (up_ready)
		begin
			s1_valid <= up_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (up_valid && up_ready)
		begin
			s1_sign <= up_sign;
			if (up_zero)
			begin
				// exponent 0 sends it down the flush path in stage 2
				s1_prod <= '0;
				s1_exp  <= '0;
			end
			else
			begin
				s1_prod <= up_sig_a * up_sig_b;
				s1_exp  <= s1_exp_next;
			end
		end
	end

	// stage 2 normalize and clamp
	always_comb
	begin
		// product of two 1.x values lies in [1, 4)
		if (s1_prod[15])
		begin
			norm_prod = s1_prod >> 1;
			norm_exp  = s1_exp + 10'sd1;
		end
		else
		begin
			norm_prod = s1_prod;
			norm_exp  = s1_exp;
		end

		s2_result_next.sign = s1_sign;

		if (norm_exp <= 10'sd0)
		begin
			// underflow or zero operand
			s2_result_next.exp      = 8'd0;
			s2_result_next.mantissa = 7'd0;
		end
		else if (norm_exp >= SAT_LIMIT)
		begin
			// no infinity, clamp to the largest finite value
			s2_result_next.exp      = MAX_EXP;
			s2_result_next.mantissa = `BF16_SAT_MANTISSA;
		end
		else
		begin
			// leading one sits in bit 14, the low bits are truncated
			s2_result_next.exp      = norm_exp[7:0];
			s2_result_next.mantissa = norm_prod[13:7];
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s2_valid <= 1'b0;
		end
		else if (s1_ready)
		begin
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (s1_valid && s1_ready)
		begin
			core_result <= s2_result_next;
		end
	end

	assign core_valid = s2_valid;

endmodule

// ==== hdl/bf16_result_queue.sv ====
`timescale 1ns/1ps
`include "bf16_settings.svh"

module bf16_result_queue
	import bf16_pkg::*;
#(
	parameter int DEPTH = `BF16_QUEUE_DEPTH
)
(
	input  logic  clk,
	input  logic  rst_n,

	// write side from the core
	input  logic  core_valid,
	output logic  core_ready,
	input  bf16_t core_result,

	// read side to the consumer
	output logic  out_valid,
	input  logic  out_ready,
	output bf16_t out_result
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	bf16_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// wraps at DEPTH, so depths that are not a power of two work too
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
		begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign core_ready = (count != CNT_W'(DEPTH));
	assign out_valid  = (count != '0);
	assign push       = core_valid && core_ready;
	assign pop        = out_valid && out_ready;

	// oldest entry always sits at the read pointer
	assign out_result = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem[wr_ptr] <= core_result;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop)
			begin
				rd_ptr <= next_ptr(rd_ptr);
			end

			// simultaneous push and pop leaves the count alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== hdl/bf16_mul_unit.sv ====
`timescale 1ns/1ps
`include "bf16_settings.svh"

module bf16_mul_unit
	import bf16_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,

	// operand pairs in
	input  logic  in_valid,
	output logic  in_ready,
	input  bf16_t in_a,
	input  bf16_t in_b,

	// products out
	output logic  out_valid,
	input  logic  out_ready,
	output bf16_t out_result
);

	// unpack to core
	logic      up_valid;
	logic      up_ready;
	logic      up_sign;
	bf16_sig_t up_sig_a;
	bf16_sig_t up_sig_b;
	bf16_exp_t up_exp_a;
	bf16_exp_t up_exp_b;
	logic      up_zero;

	// core to queue
	logic      core_valid;
	logic      core_ready;
	bf16_t     core_result;

	bf16_operand_unpack unpack_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_a     (in_a),
		.in_b     (in_b),
		.up_valid (up_valid),
		.up_ready (up_ready),
		.up_sign  (up_sign),
		.up_sig_a (up_sig_a),
		.up_sig_b (up_sig_b),
		.up_exp_a (up_exp_a),
		.up_exp_b (up_exp_b),
		.up_zero  (up_zero)
	);

	// two pipeline stages, multiply then normalize
	bf16_mul_core core_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.up_valid    (up_valid),
		.up_ready    (up_ready),
		.up_sign     (up_sign),
		.up_sig_a    (up_sig_a),
		.up_sig_b    (up_sig_b),
		.up_exp_a    (up_exp_a),
		.up_exp_b    (up_exp_b),
		.up_zero     (up_zero),
		.core_valid  (core_valid),
		.core_ready  (core_ready),
		.core_result (core_result)
	);

	bf16_result_queue #(
		.DEPTH (`BF16_QUEUE_DEPTH)
	) queue_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.core_valid  (core_valid),
		.core_ready  (core_ready),
		.core_result (core_result),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_result  (out_result)
	);

endmodule

// ==== dv/bf16_mul_unit_assertions.sv ====
`timescale 1ns/1ps

module bf16_mul_unit_assertions
	import bf16_pkg::*;
(
	input logic  clk,
	input logic  rst_n,
	input logic  in_ready,
	input logic  core_valid,
	input logic  core_ready,
	input logic  out_valid,
	input logic  out_ready,
	input bf16_t out_result
);

	logic queue_push;
	logic queue_pop;
	int   queue_fill;

	// queue fill level rebuilt from the push and pop handshakes
	assign queue_push = core_valid && core_ready;
	assign queue_pop  = out_valid && out_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			queue_fill <= 0;
		end
		else if (queue_push && !queue_pop)
		begin
			queue_fill <= queue_fill + 1;
		end
		else if (queue_pop && !queue_push)
		begin
			queue_fill <= queue_fill - 1;
		end
	end

	// a presented result holds until it is taken
	property out_hold;
		@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_result);
	endproperty

	// clean state right after reset release
	property reset_state;
		@(posedge clk)
		$rose(rst_n) |-> in_ready && !out_valid;
	endproperty

	property no_pop_when_empty;
		@(posedge clk) disable iff (!rst_n)
		out_valid && out_ready |-> queue_fill != 0;
	endproperty

	out_hold_a: assert property (out_hold)
		else $error("out_valid dropped or out_result changed before out_ready");

	reset_state_a: assert property (reset_state)
		else $error("in_ready low or out_valid high right after reset");

	no_pop_when_empty_a: assert property (no_pop_when_empty)
		else $error("output transfer while the result queue is empty");

endmodule

bind bf16_mul_unit bf16_mul_unit_assertions checker_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_ready   (in_ready),
	.core_valid (core_valid),
	.core_ready (core_ready),
	.out_valid  (out_valid),
	.out_ready  (out_ready),
	.out_result (out_result)
);

// ==== dv/bf16_mul_unit_tb.sv ====
`timescale 1ns/1ps
`include "bf16_settings.svh"

module bf16_mul_unit_tb
	import bf16_pkg::*;
;

	localparam logic [31:0] SEED = 32'hf0d0226d;
	localparam int RANDOM_OPS     = 2000;
	localparam int CORNER_OPS     = 16;
	localparam int TOTAL_OPS      = 3 + 3 * CORNER_OPS + 2 * RANDOM_OPS;
	localparam int TIMEOUT_CYCLES = TOTAL_OPS * 20 + 1000;
	localparam int DRAIN_CYCLES   = 500;

	logic  clk;
	logic  rst_n;
	logic  in_valid;
	logic  in_ready;
	bf16_t in_a;
	bf16_t in_b;
	logic  out_valid;
	logic  out_ready;
	bf16_t out_result;

	bf16_t       exp_q[$];
	int          error_count;
	int          checked_count;
	logic        random_ready;
	logic [31:0] rng_stim;
	logic [31:0] rng_flow;
	logic [31:0] rng_ready;

	bf16_mul_unit dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_a       (in_a),
		.in_b       (in_b),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// flush, truncate, flush on underflow, clamp on overflow
	function automatic bf16_t bf16_mul_ref(input bf16_t a, input bf16_t b);
		bf16_t       r;
		logic [15:0] prod;
		int          e;
		r.sign     = a.sign ^ b.sign;
		r.exp      = 8'd0;
		r.mantissa = 7'd0;
		if (a.exp == 8'd0 || b.exp == 8'd0)
			return r;
		prod = {1'b1, a.mantissa} * {1'b1, b.mantissa};
		e = int'(a.exp) + int'(b.exp) - `BF16_EXP_BIAS;
		if (prod[15])
		begin
			e = e + 1;
			r.mantissa = prod[14:8];
		end
		else
			r.mantissa = prod[13:7];
		if (e <= 0)
		begin
			r.exp      = 8'd0;
			r.mantissa = 7'd0;
		end
		else if (e >= 255)
		begin
			r.exp      = `BF16_MAX_EXP;
			r.mantissa = `BF16_SAT_MANTISSA;
		end
		else
			r.exp = e[7:0];
		return r;
	endfunction

	task automatic compare_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected)
		begin
			$display("Error %s: expected %h, got %h", name, expected, actual);
			error_count++;
		end
	endtask

	// called on a falling edge, returns on the falling edge after the transfer
	task automatic send_pair(input bf16_t a, input bf16_t b);
		logic taken;
		in_valid = 1'b1;
		in_a     = a;
		in_b     = b;
		taken    = 1'b0;
		while (!taken)
		begin
			taken = in_ready;
			@(negedge clk);
		end
		in_valid = 1'b0;
	endtask

	// returns once every expected result came out or the drain limit passed
	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_CYCLES)
		begin
			@(negedge clk);
			waited++;
		end
	endtask

	function automatic bf16_t next_operand();
		rng_stim = xorshift32(rng_stim);
		return bf16_t'(rng_stim[23:8]);
	endfunction

	// expected results in on input transfers, compared on output transfers
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (in_valid && in_ready)
				exp_q.push_back(bf16_mul_ref(in_a, in_b));
			if (out_valid && out_ready)
			begin
				if (exp_q.size() == 0)
				begin
					$display("Result %h came out with no operand pair outstanding", out_result);
					error_count++;
				end
				else
				begin
					compare_value("out_result", exp_q.pop_front(), out_result);
					checked_count++;
				end
			end
		end
	end

	// consumer with random drops and an occasional long stall
	initial
	begin
		out_ready = 1'b1;
		forever
		begin
			@(negedge clk);
			if (!random_ready)
				out_ready = 1'b1;
			else
			begin
				rng_ready = xorshift32(rng_ready);
				if (rng_ready[7:0] == 8'd0)
				begin
					out_ready = 1'b0;
					repeat (20 + rng_ready[12:8]) @(negedge clk);
				end
				else
					out_ready = (rng_ready[9:8] != 2'd0);
			end
		end
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, results still outstanding: %0d",
			TIMEOUT_CYCLES, exp_q.size());
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		bf16_t a;
		bf16_t b;
		rst_n         = 1'b0;
		in_valid      = 1'b0;
		in_a          = '0;
		in_b          = '0;
		random_ready  = 1'b0;
		error_count   = 0;
		checked_count = 0;
		rng_stim      = SEED;
		rng_flow      = xorshift32(SEED);
		rng_ready     = {SEED[15:0], SEED[31:16]};
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// known answers for the reference itself
		compare_value("bf16_mul_ref", 16'h40c0, bf16_mul_ref(16'h4000, 16'h4040));
		compare_value("bf16_mul_ref", 16'h4010, bf16_mul_ref(16'h3fc0, 16'h3fc0));
		compare_value("bf16_mul_ref", 16'hc0c0, bf16_mul_ref(16'hc000, 16'h4040));

		// exact products 2 x 3, 1.5 x 1.5 and -2 x 3
		send_pair(16'h4000, 16'h4040);
		send_pair(16'h3fc0, 16'h3fc0);
		send_pair(16'hc000, 16'h4040);

		// zero exponent on either side
		for (int i = 0; i < CORNER_OPS; i++)
		begin
			a = next_operand();
			b = next_operand();
			if (i[0])
				a.exp = 8'd0;
			else
				b.exp = 8'd0;
			send_pair(a, b);
		end

		// underflow from small times small
		for (int i = 0; i < CORNER_OPS; i++)
		begin
			a = next_operand();
			b = next_operand();
			a.exp = 8'(1 + rng_stim[7:0] % 40);
			b.exp = 8'(1 + rng_stim[31:24] % 40);
			send_pair(a, b);
		end

		// overflow from large times large
		for (int i = 0; i < CORNER_OPS; i++)
		begin
			a = next_operand();
			b = next_operand();
			a.exp = 8'(200 + rng_stim[7:0] % 55);
			b.exp = 8'(200 + rng_stim[31:24] % 55);
			send_pair(a, b);
		end
		wait_drain();

		// back-to-back stream with the consumer always ready
		rng_stim = SEED;
		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			a = next_operand();
			b = next_operand();
			send_pair(a, b);
		end
		wait_drain();

		// same stream again with input gaps and consumer stalls
		random_ready = 1'b1;
		rng_stim     = SEED;
		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			a = next_operand();
			b = next_operand();
			rng_flow = xorshift32(rng_flow);
			if (rng_flow[9:4] == 6'd0)
				repeat (30) @(negedge clk);
			else if (rng_flow[3:0] < 4'd5)
				repeat (rng_flow[6:4]) @(negedge clk);
			send_pair(a, b);
		end
		wait_drain();
		random_ready = 1'b0;

		// nothing extra may come out afterwards
		repeat (10) @(negedge clk);
		compare_value("out_valid", 16'h0, {15'h0, out_valid});
		if (exp_q.size() != 0)
		begin
			$display("Expected-result queue still holds %0d entries", exp_q.size());
			error_count++;
		end

		$display("Checked %0d results, %0d errors", checked_count, error_count);
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/bf16_pkg.sv
hdl/bf16_operand_unpack.sv
hdl/bf16_mul_core.sv
hdl/bf16_result_queue.sv
hdl/bf16_mul_unit.sv
dv/bf16_mul_unit_assertions.sv
dv/bf16_mul_unit_tb.sv
